// ==== tb.f ====
+incdir+common
common/uartLinePkg.sv
common/uartHostPkg.sv
logic/baudTickGen.sv
logic/syncFifo.sv
uart/uartTrans.sv
uart/uartRecv.sv
uart/uartStatus.sv
uart/uartPeriph.sv
dv/uartPeriphTb.sv

// ==== run.sh ====
#!/bin/sh
# Verilator build and run of the uart peripheral testbench
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert -j 0 -f tb.f --top-module uartPeriphTb -o uartSim \
	&& ./obj_dir/uartSim | tee sim.log \
	|| echo "build or simulation error"
grep -q "ALL CHECKS PASSED" sim.log && echo "result: pass" && exit 0
echo "result: fail"
exit 1

// ==== dv/uartPeriphTb.sv ====
// uart peripheral testbench: loopback and bit-banged frames checked against a queue model
`timescale 1ns/1ps
`include "uart_macros.svh"

module uartPeriphTb;

	localparam int clkPeriod     = 20;
	localparam int frameCycles   = 160 * `uartClocksPerTick;  // 10 bits of 16 ticks
	localparam int bangBitCycles = 16 * `uartClocksPerTick;   // one bit on the banged line
	localparam int overFrames    = `uartRxFifoDepth + 2;      // two more than the rx FIFO holds
	localparam int framesTotal   = 20 + `uartTxFifoDepth + overFrames + 2;
	localparam int slackCycles   = 8800;                      // write gaps, reads, idle waits
	localparam int timeoutCycles = 2 * framesTotal * frameCycles + slackCycles;

	logic                     clk;
	logic                     reset;
	logic                     wrStrobe;
	logic [`uartDataBits-1:0] wrData;
	logic                     rdStrobe;
	logic                     statusRd;
	uartLinePkg::rxFrame_t    rdFrame;
	uartHostPkg::uartStatus_t status;
	logic                     tx;
	logic                     rx;
	logic                     lineSel;   // 0 tx looped back, 1 bit-banger
	logic                     bangLine;  // bit-banger output, idles high

	logic [31:0]              lfsrState;
	uartLinePkg::rxFrame_t    expQ[$];   // frames the rx FIFO should hand back, in order
	logic                     modelOverrun;
	string                    testName;
	int                       cycleCount;
	int                       checkCount, errCount;
	int                       testChecks, testErrs;

	assign rx = lineSel ? bangLine : tx;

	uartPeriph u_dut
	(
		.clk      (clk),
		.reset    (reset),
		.wrStrobe (wrStrobe),
		.wrData   (wrData),
		.rdStrobe (rdStrobe),
		.statusRd (statusRd),
		.rdFrame  (rdFrame),
		.status   (status),
		.tx       (tx),
		.rx       (rx)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#(clkPeriod / 2) clk = ~clk;
	end

	// hang guard, counts every clock of the run
	initial
	begin
		cycleCount = 0;
		while (cycleCount < timeoutCycles)
		begin
			@(posedge clk);
			cycleCount++;
		end
		$display("timeout: test %s still running after %0d cycles", testName, timeoutCycles);
		$display("CHECKS FAILED");
		$finish;
	end

	//////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////

	// x^32 + x^22 + x^2 + x + 1, right shifting Galois form
	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h8020_0003;
		return s >> 1;
	endfunction

	task automatic takeBits(input int n, output logic [7:0] v);
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			v[i]      = lfsrState[0];  // one step per bit
			lfsrState = lfsrStep(lfsrState);
		end
	endtask

	function automatic uartLinePkg::rxFrame_t makeFrame(input logic [7:0] b, input logic err);
		uartLinePkg::rxFrame_t f;
		f.data     = b;
		f.frameErr = err;
		return f;
	endfunction

	// only the two empty flags set
	function automatic uartHostPkg::uartStatus_t idleStatus();
		uartHostPkg::uartStatus_t s;
		s         = '0;
		s.txEmpty = 1'b1;
		s.rxEmpty = 1'b1;
		return s;
	endfunction

	task automatic checkEq(input logic [31:0] got, input logic [31:0] expVal, input string what);
		checkCount++;
		testChecks++;
		assert (got == expVal)
		else
		begin
			errCount++;
			testErrs++;
			$display("FAILED %0t: %s got 0x%0h, expected 0x%0h", $time, what, got, expVal);
		end
	endtask

	task automatic waitCycle();
		@(posedge clk);
		#2;  // inputs change clear of the edge
	endtask

	task automatic waitCycles(input int n);
		repeat (n)
			waitCycle();
	endtask

	task automatic startTest(input string name);
		testName   = name;
		testChecks = 0;
		testErrs   = 0;
	endtask

	task automatic endTest();
		$display("test %s: %0d checks, %0d errors", testName, testChecks, testErrs);
	endtask

	// writes wait for room, the DUT drops writes on a full FIFO
	task automatic writeByte(input logic [7:0] b);
		while (status.txFull)
			waitCycle();
		wrData   = b;
		wrStrobe = 1'b1;
		waitCycle();
		wrStrobe = 1'b0;
	endtask

	task automatic readCheck();
		uartLinePkg::rxFrame_t expFrame;
		while (status.rxEmpty)
			waitCycle();
		checkCount++;
		testChecks++;
		assert (expQ.size() != 0)
		else
		begin
			errCount++;
			testErrs++;
			$display("frame 0x%0h came out of the rx FIFO but none was expected", rdFrame);
		end
		if (expQ.size() != 0)
		begin
			expFrame = expQ.pop_front();
			checkEq(32'(rdFrame), 32'(expFrame), "rx frame {frameErr, data}");
		end
		rdStrobe = 1'b1;  // pop, new head next cycle
		waitCycle();
		rdStrobe = 1'b0;
	endtask

	task automatic bangFrame(input logic [7:0] b, input logic stopBit);
		bangLine = 1'b0;  // start
		waitCycles(bangBitCycles);
		for (int i = 0; i < 8; i++)
		begin
			bangLine = b[i];  // LSB first
			waitCycles(bangBitCycles);
		end
		bangLine = stopBit;
		waitCycles(bangBitCycles);
		bangLine = 1'b1;  // idle gap before next start
		waitCycles(bangBitCycles);
	endtask

	task automatic sendRandom(input int n);
		logic [7:0] b, gap;
		for (int i = 0; i < n; i++)
		begin
			takeBits(8, b);
			takeBits(4, gap);
			expQ.push_back(makeFrame(b, 1'b0));
			writeByte(b);
			waitCycles(int'(gap));
		end
	endtask

	//////////////////////////////////////////////////
	// tests
	//////////////////////////////////////////////////

	task automatic resetCheck();
		startTest("reset");
		checkEq(32'(tx), 32'd1, "tx idle level");
		checkEq(32'(status), 32'(idleStatus()), "status after reset");
		endTest();
	endtask

	task automatic randomLoopback();
		startTest("random loopback");
		lineSel = 1'b0;
		fork
			sendRandom(20);
			repeat (20)
				readCheck();
		join
		while (status.txBusy)  // last stop bit still on the line
			waitCycle();
		checkEq(32'(status), 32'(idleStatus()), "status after random loopback");
		endTest();
	endtask

	task automatic burstLoopback();
		logic [7:0] b;
		startTest("burst loopback");
		for (int i = 0; i < `uartTxFifoDepth; i++)
		begin
			takeBits(8, b);
			expQ.push_back(makeFrame(b, 1'b0));
			writeByte(b);
		end
		checkEq(32'(status.txBusy), 32'd1, "txBusy after burst");
		repeat (`uartTxFifoDepth)
			readCheck();
		while (status.txBusy)  // last stop bit still going out
			waitCycle();
		checkEq(32'(status), 32'(idleStatus()), "status after burst drained");
		endTest();
	endtask

	task automatic overrunFill();
		logic [7:0] b;
		startTest("rx overrun");
		for (int i = 0; i < overFrames; i++)
		begin
			takeBits(8, b);
			if (i < `uartRxFifoDepth)
				expQ.push_back(makeFrame(b, 1'b0));
			else
				modelOverrun = 1'b1;  // FIFO already full, frame lost
			writeByte(b);
		end
		while (!status.txEmpty || status.txBusy)
			waitCycle();
		waitCycles(bangBitCycles);  // margin for the last receive
		checkEq(32'(status.rxFull), 32'd1, "rxFull with no reads");
		checkEq(32'(status.overrun), 32'(modelOverrun), "overrun after lost frames");
		statusRd = 1'b1;
		waitCycle();
		statusRd     = 1'b0;
		modelOverrun = 1'b0;
		checkEq(32'(status.overrun), 32'(modelOverrun), "overrun after status read");
		repeat (`uartRxFifoDepth)
			readCheck();
		checkEq(32'(status), 32'(idleStatus()), "status after draining rx FIFO");
		endTest();
	endtask

	task automatic frameErrBang();
		logic [7:0] b;
		startTest("bad stop bit");
		lineSel = 1'b1;  // tx idle here, switch is glitch free
		takeBits(8, b);
		expQ.push_back(makeFrame(b, 1'b1));
		bangFrame(b, 1'b0);
		takeBits(8, b);
		expQ.push_back(makeFrame(b, 1'b0));
		bangFrame(b, 1'b1);
		repeat (2)
			readCheck();
		endTest();
	endtask

	//////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////

	initial
	begin
		reset        = 1'b1;
		wrStrobe     = 1'b0;
		wrData       = '0;
		rdStrobe     = 1'b0;
		statusRd     = 1'b0;
		lineSel      = 1'b0;
		bangLine     = 1'b1;
		lfsrState    = 32'd72216;
		modelOverrun = 1'b0;
		checkCount   = 0;
		errCount     = 0;
		testName     = "reset";
		repeat (5)
			@(posedge clk);
		#2;
		reset = 1'b0;
		waitCycle();

		resetCheck();
		randomLoopback();
		burstLoopback();
		overrunFill();
		frameErrBang();

		$display("summary: %0d checks, %0d errors", checkCount, errCount);
		if (errCount == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

// ==== uart/uartPeriph.sv ====
// uart peripheral top: tick generator, tx FIFO and transmitter, receiver and rx FIFO, status
`timescale 1ns/1ps
`include "uart_macros.svh"

module uartPeriph
#(
	parameter int clocksPerTick = `uartClocksPerTick
)
(
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     wrStrobe,
	input  logic [`uartDataBits-1:0] wrData,
	input  logic                     rdStrobe,
	input  logic                     statusRd,
	output uartLinePkg::rxFrame_t    rdFrame,
	output uartHostPkg::uartStatus_t status,
	output logic                     tx,
	input  logic                     rx
);

	logic                     sTick;
	logic [`uartDataBits-1:0] txHead;
	logic                     txEmpty, txFull, txDoneTick, txBusy;
	uartLinePkg::rxFrame_t    rxFrame;
	logic                     rxDoneTick, rxEmpty, rxFull;
	logic                     rxDrop;

	baudTickGen #(.clocksPerTick(clocksPerTick)) uTick
	(
		.clk   (clk),
		.reset (reset),
		.sTick (sTick)
	);

	//////////////////////////////////////////////////
	// transmit path
	//////////////////////////////////////////////////

	syncFifo #(.payload_t(logic [`uartDataBits-1:0]), .depth(`uartTxFifoDepth)) uTxFifo
	(
		.clk      (clk),
		.reset    (reset),
		.push     (wrStrobe),  // dropped silently when full
		.pushData (wrData),
		.pop      (txDoneTick),
		.head     (txHead),
		.empty    (txEmpty),
		.full     (txFull)
	);

	uartTrans uTrans
	(
		.clk        (clk),
		.reset      (reset),
		.sTick      (sTick),
		.txStart    (!txEmpty),  // anything queued starts a frame
		.din        (txHead),
		.txDoneTick (txDoneTick),
		.txBusy     (txBusy),
		.tx         (tx)
	);

	//////////////////////////////////////////////////
	// receive path
	//////////////////////////////////////////////////

	uartRecv uRecv
	(
		.clk        (clk),
		.reset      (reset),
		.sTick      (sTick),
		.rx         (rx),
		.rxDoneTick (rxDoneTick),
		.rxFrame    (rxFrame)
	);

	syncFifo #(.payload_t(uartLinePkg::rxFrame_t), .depth(`uartRxFifoDepth)) uRxFifo
	(
		.clk      (clk),
		.reset    (reset),
		.push     (rxDoneTick),
		.pushData (rxFrame),
		.pop      (rdStrobe),  // no effect when empty
		.head     (rdFrame),
		.empty    (rxEmpty),
		.full     (rxFull)
	);

	assign rxDrop = rxDoneTick && rxFull;  // frame the FIFO refused

	uartStatus uStatus
	(
		.clk      (clk),
		.reset    (reset),
		.txFull   (txFull),
		.txEmpty  (txEmpty),
		.txBusy   (txBusy),
		.rxEmpty  (rxEmpty),
		.rxFull   (rxFull),
		.rxDrop   (rxDrop),
		.statusRd (statusRd),
		.status   (status)
	);

endmodule

// ==== uart/uartStatus.sv ====
// uart status: builds the host status word and keeps the sticky overrun flag
`timescale 1ns/1ps

module uartStatus
(
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     txFull,
	input  logic                     txEmpty,
	input  logic                     txBusy,
	input  logic                     rxEmpty,
	input  logic                     rxFull,
	input  logic                     rxDrop,    // frame lost, rx FIFO full
	input  logic                     statusRd,  // host read, clears overrun
	output uartHostPkg::uartStatus_t status
);

	logic overrunReg;

	// sticky until read, a drop in the read cycle still sets it
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			overrunReg <= 1'b0;
		else if (rxDrop)
			overrunReg <= 1'b1;
		else if (statusRd)
			overrunReg <= 1'b0;
	end

	// flags come straight from registered FIFO counts and FSM state
	always_comb
	begin
		status.spare   = 2'b00;
		status.overrun = overrunReg;
		status.rxFull  = rxFull;
		status.rxEmpty = rxEmpty;
		status.txBusy  = txBusy;
		status.txEmpty = txEmpty;
		status.txFull  = txFull;
	end

endmodule

// ==== uart/uartRecv.sv ====
// uart receiver: 16x oversampling, mid-bit sampling, stop bit check per frame
`timescale 1ns/1ps
`include "uart_macros.svh"

module uartRecv
(
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  sTick,
	input  logic                  rx,
	output logic                  rxDoneTick,  // one cycle, mid stop bit
	output uartLinePkg::rxFrame_t rxFrame
);

	localparam int bitTicks = 16;
	localparam int halfBit  = bitTicks / 2;
	localparam int nW       = $clog2(`uartDataBits);

	uartLinePkg::rxState_e    stateReg, stateNext;
	logic [3:0]               sReg, sNext;
	logic [nW-1:0]            nReg, nNext;
	logic [`uartDataBits-1:0] bReg, bNext;  // assembled byte
	logic                     rxMeta, rxSync, rxDly;
	logic                     fallEdge;

	//////////////////////////////////////////////////
	// synchronizer and edge detect
	//////////////////////////////////////////////////

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			rxMeta <= 1'b1;  // line idles high
			rxSync <= 1'b1;
			rxDly  <= 1'b1;
		end
		else
		begin
			rxMeta <= rx;
			rxSync <= rxMeta;
			rxDly  <= rxSync;
		end
	end

	// edge, not level, so a low bad stop bit does not restart
	assign fallEdge = rxDly && !rxSync;

	//////////////////////////////////////////////////
	// state registers
	//////////////////////////////////////////////////

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			stateReg <= uartLinePkg::rxIdle;
			sReg     <= '0;
			nReg     <= '0;
		end
		else
		begin
			stateReg <= stateNext;
			sReg     <= sNext;
			nReg     <= nNext;
		end
	end

	always_ff @(posedge clk)
		bReg <= bNext;

	always_comb
	begin
		stateNext  = stateReg;
		sNext      = sReg;
		nNext      = nReg;
		bNext      = bReg;
		rxDoneTick = 1'b0;

		case (stateReg)
			uartLinePkg::rxIdle:
				if (fallEdge)
				begin
					sNext     = '0;
					stateNext = uartLinePkg::rxStartBit;
				end

			uartLinePkg::rxStartBit:
				if (sTick)
				begin
					if (sReg == 4'(halfBit - 1))
					begin
						// still low at mid start bit, else a glitch
						sNext     = '0;
						nNext     = '0;
						stateNext = rxSync ? uartLinePkg::rxIdle : uartLinePkg::rxDataBit;
					end
					else
						sNext = sReg + 1'b1;
				end

			uartLinePkg::rxDataBit:
				if (sTick)
				begin
					if (sReg == 4'(bitTicks - 1))
					begin
						sNext = '0;
						bNext = {rxSync, bReg[`uartDataBits-1:1]};  // LSB first, shift right
						if (nReg == nW'(`uartDataBits - 1))
							stateNext = uartLinePkg::rxStopBit;
						else
							nNext = nReg + 1'b1;
					end
					else
						sNext = sReg + 1'b1;
				end

			uartLinePkg::rxStopBit:
				if (sTick)
				begin
					if (sReg == 4'(bitTicks - 1))
					begin
						rxDoneTick = 1'b1;  // deliver, good stop or not
						stateNext  = uartLinePkg::rxIdle;
					end
					else
						sNext = sReg + 1'b1;
				end
		endcase
	end

	// frameErr meaningful on rxDoneTick, sampled stop bit
	assign rxFrame.data     = bReg;
	assign rxFrame.frameErr = !rxSync;

endmodule

// ==== uart/uartTrans.sv ====
// uart transmitter: start, 8 data bits LSB first, stop bit, paced by the baud tick
`timescale 1ns/1ps
`include "uart_macros.svh"

module uartTrans
(
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     sTick,
	input  logic                     txStart,     // FIFO not empty
	input  logic [`uartDataBits-1:0] din,         // FIFO head
	output logic                     txDoneTick,  // FIFO pop
	output logic                     txBusy,
	output logic                     tx
);

	localparam int bitTicks = 16;  // ticks per bit at 16x
	localparam int nW       = $clog2(`uartDataBits);

	uartLinePkg::txState_e    stateReg, stateNext;
	logic [3:0]               sReg, sNext;  // tick count inside a bit
	logic [nW-1:0]            nReg, nNext;  // data bit index
	logic [`uartDataBits-1:0] bReg, bNext;  // shift register, LSB goes out
	logic                     txReg, txNext;

	//////////////////////////////////////////////////
	// state registers
	//////////////////////////////////////////////////

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			stateReg <= uartLinePkg::txIdle;
			sReg     <= '0;
			nReg     <= '0;
			txReg    <= 1'b1;  // idle line high
		end
		else
		begin
			stateReg <= stateNext;
			sReg     <= sNext;
			nReg     <= nNext;
			txReg    <= txNext;
		end
	end

	always_ff @(posedge clk)
		bReg <= bNext;  // payload only

	//////////////////////////////////////////////////
	// next state
	//////////////////////////////////////////////////

	always_comb
	begin
		stateNext  = stateReg;
		sNext      = sReg;
		nNext      = nReg;
		bNext      = bReg;
		txNext     = txReg;
		txDoneTick = 1'b0;

		case (stateReg)
			uartLinePkg::txIdle:
			begin
				txNext = 1'b1;
				if (txStart)
				begin
					// pop and grab the head together
					txDoneTick = 1'b1;
					bNext      = din;
					sNext      = '0;
					stateNext  = uartLinePkg::txStartBit;
				end
			end

			uartLinePkg::txStartBit:
			begin
				txNext = 1'b0;  // start bit
				if (sTick)
				begin
					if (sReg == 4'(bitTicks - 1))
					begin
						sNext     = '0;
						nNext     = '0;
						stateNext = uartLinePkg::txDataBit;
					end
					else
						sNext = sReg + 1'b1;
				end
			end

			uartLinePkg::txDataBit:
			begin
				txNext = bReg[0];
				if (sTick)
				begin
					if (sReg == 4'(bitTicks - 1))
					begin
						sNext = '0;
						bNext = bReg >> 1;  // next bit into LSB
						if (nReg == nW'(`uartDataBits - 1))
							stateNext = uartLinePkg::txStopBit;
						else
							nNext = nReg + 1'b1;
					end
					else
						sNext = sReg + 1'b1;
				end
			end

			uartLinePkg::txStopBit:
			begin
				txNext = 1'b1;
				if (sTick)
				begin
					if (sReg == 4'(`uartSbTick - 1))
						stateNext = uartLinePkg::txIdle;  // next byte can pop right away
					else
						sNext = sReg + 1'b1;
				end
			end
		endcase
	end

	assign txBusy = (stateReg != uartLinePkg::txIdle);
	assign tx     = txReg;  // registered, no glitches on the line

endmodule

// ==== logic/syncFifo.sv ====
// synchronous FIFO: show-ahead circular buffer, payload chosen by type parameter
`timescale 1ns/1ps

module syncFifo
#(
	parameter type payload_t = logic [7:0],
	parameter int  depth     = 8
)
(
	input  logic     clk,
	input  logic     reset,
	input  logic     push,
	input  payload_t pushData,
	input  logic     pop,
	output payload_t head,
	output logic     empty,
	output logic     full
);

	localparam int ptrW = (depth > 1) ? $clog2(depth) : 1;
	localparam int cntW = $clog2(depth + 1);

	payload_t        mem [depth];
	logic [ptrW-1:0] wrPtr, rdPtr;
	logic [cntW-1:0] count;  // entries held
	logic            doPush, doPop;

	assign empty = (count == '0);
	assign full  = (count == cntW'(depth));

	// push on full and pop on empty are dropped
	assign doPush = push && !full;
	assign doPop  = pop && !empty;

	assign head = mem[rdPtr];  // show-ahead, head valid while not empty

	//////////////////////////////////////////////////
	// storage, no reset
	//////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (doPush)
			mem[wrPtr] <= pushData;
	end

	//////////////////////////////////////////////////
	// pointers and fill count
	//////////////////////////////////////////////////

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (doPush)
				wrPtr <= (wrPtr == ptrW'(depth - 1)) ? '0 : wrPtr + 1'b1;  // wrap at depth
			if (doPop)
				rdPtr <= (rdPtr == ptrW'(depth - 1)) ? '0 : rdPtr + 1'b1;
			case ({doPush, doPop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;  // both or neither, no change
			endcase
		end
	end

endmodule

// ==== logic/baudTickGen.sv ====
// baud tick generator: one-cycle pulse every clocksPerTick clocks for 16x oversampling
`timescale 1ns/1ps
`include "uart_macros.svh"

module baudTickGen
#(
	parameter int clocksPerTick = `uartClocksPerTick
)
(
	input  logic clk,
	input  logic reset,
	output logic sTick
);

	localparam int cntW = (clocksPerTick > 1) ? $clog2(clocksPerTick) : 1;

	logic [cntW-1:0] count;  // free running divider

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			count <= '0;
			sTick <= 1'b0;
		end
		else if (count == cntW'(clocksPerTick - 1))
		begin
			count <= '0;    // wrap
			sTick <= 1'b1;  // pulse on wrap only
		end
		else
		begin
			count <= count + 1'b1;
			sTick <= 1'b0;
		end
	end

endmodule

// ==== common/uartHostPkg.sv ====
// uart host package: status word seen by the processor on a status read
package uartHostPkg;

	// txFull ends up in bit 0
	typedef struct packed
	{
		logic [1:0] spare;    // reads zero
		logic       overrun;  // sticky, frame lost on full rx FIFO
		logic       rxFull;
		logic       rxEmpty;
		logic       txBusy;   // transmitter not idle
		logic       txEmpty;
		logic       txFull;
	} uartStatus_t;

endpackage

// ==== common/uartLinePkg.sv ====
// uart line package: serial engine state encodings and the received frame
`include "uart_macros.svh"

package uartLinePkg;

	// transmitter states
	typedef enum logic [1:0]
	{
		txIdle     = 2'b00,  // line high, waiting for data
		txStartBit = 2'b01,
		txDataBit  = 2'b10,
		txStopBit  = 2'b11
	} txState_e;

	// receiver states, same walk through the frame
	typedef enum logic [1:0]
	{
		rxIdle     = 2'b00,  // hunting for falling edge
		rxStartBit = 2'b01,
		rxDataBit  = 2'b10,
		rxStopBit  = 2'b11
	} rxState_e;

	// one frame as it sits in the rx FIFO
	typedef struct packed
	{
		logic                     frameErr;  // stop bit sampled low
		logic [`uartDataBits-1:0] data;
	} rxFrame_t;

endpackage

// ==== common/uart_macros.svh ====
// uart macros: frame format, FIFO depths and the default baud tick rate
`ifndef UART_MACROS_SVH
`define UART_MACROS_SVH

//////////////////////////////////////////////////
// frame format
//////////////////////////////////////////////////

`define uartDataBits       8   // data bits per frame
`define uartSbTick         16  // ticks in stop bit, 16 = one stop bit

//////////////////////////////////////////////////
// buffering
//////////////////////////////////////////////////

`define uartTxFifoDepth    8   // bytes waiting to go out
`define uartRxFifoDepth    8   // frames waiting for the host

//////////////////////////////////////////////////
// baud rate
//////////////////////////////////////////////////

// clk cycles per 16x oversampling tick
`define uartClocksPerTick  4

`endif
